// ==== source/mips_pkg.sv ====
package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////

    localparam int NB_PC  = 32;                   // Width of data, PC and ALU values
    localparam int NB_REG = 5;                    // Width of a register index

    typedef logic [NB_PC-1:0]  word_t;            // One 32-bit word
    typedef logic [NB_REG-1:0] reg_idx_t;         // Register file index, 31 is the link

    ////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////

    // Shift amounts come from the low five bits of operand b
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_nor = 4'd5,
        alu_slt = 4'd6,                           // Signed compare
        alu_sll = 4'd7,
        alu_srl = 4'd8
    } alu_op_t;

endpackage

// ==== source/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::word_t   operand_a,
    input  mips_pkg::word_t   operand_b,
    input  mips_pkg::word_t   imm,
    input  mips_pkg::word_t   pc,
    output mips_pkg::word_t   alu_result,
    output mips_pkg::word_t   branch_addr,
    output logic              zero
);

    import mips_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    word_t      pc_plus_4;
    word_t      imm_words;

    assign shamt     = operand_b[4:0];
    assign lt_signed = $signed(operand_a) < $signed(operand_b);

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_result = operand_a + operand_b;
            end
            alu_sub: begin
                alu_result = operand_a - operand_b;
            end
            alu_and: begin
                alu_result = operand_a & operand_b;
            end
            alu_or: begin
                alu_result = operand_a | operand_b;
            end
            alu_xor: begin
                alu_result = operand_a ^ operand_b;
            end
            alu_nor: begin
                alu_result = ~(operand_a | operand_b);
            end
            alu_slt: begin
                alu_result = {{(NB_PC-1){1'b0}}, lt_signed};
            end
            alu_sll: begin
                alu_result = operand_a << shamt;
            end
            alu_srl: begin
                alu_result = operand_a >> shamt;    // Logical, fills with zeros
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    assign zero = (alu_result == '0);           // Used by the MEM stage branch decision

    ////////////////////////////////////////////////////////////
    // Branch target
    ////////////////////////////////////////////////////////////

    // The immediate is a word offset relative to the next instruction
    assign pc_plus_4   = pc + word_t'(4);
    assign imm_words   = imm << 2;
    assign branch_addr = pc_plus_4 + imm_words;

endmodule

// ==== source/ex_mem_reg.sv ====
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic                 i_clock,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 ex_valid,
    input  logic                 ex_reg_write,
    input  logic                 ex_mem_to_reg,
    input  logic                 ex_mem_read,
    input  logic                 ex_mem_write,
    input  logic                 ex_branch,
    input  logic                 ex_byte_en,
    input  logic                 ex_halfword_en,
    input  logic                 ex_word_en,
    input  logic                 ex_r31_ctrl,
    input  logic                 ex_hlt,
    input  mips_pkg::word_t      ex_branch_addr,
    input  logic                 ex_zero,
    input  mips_pkg::word_t      ex_alu_result,
    input  mips_pkg::word_t      ex_data_b,
    input  mips_pkg::reg_idx_t   ex_selected_reg,
    input  mips_pkg::word_t      ex_pc,
    output logic                 mem_valid,
    output logic                 mem_reg_write,
    output logic                 mem_mem_to_reg,
    output logic                 mem_mem_read,
    output logic                 mem_mem_write,
    output logic                 mem_branch,
    output logic                 mem_byte_en,
    output logic                 mem_halfword_en,
    output logic                 mem_word_en,
    output logic                 mem_r31_ctrl,
    output logic                 mem_hlt,
    output mips_pkg::word_t      mem_branch_addr,
    output logic                 mem_zero,
    output mips_pkg::word_t      mem_alu_result,
    output mips_pkg::word_t      mem_data_b,
    output mips_pkg::reg_idx_t   mem_selected_reg,
    output mips_pkg::word_t      mem_pc
);

    ////////////////////////////////////////////////////////////
    // Control bits, cleared by reset and by flush
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock or negedge rst_n) begin
        if (!rst_n) begin
            {mem_valid, mem_reg_write, mem_mem_to_reg, mem_mem_read, mem_mem_write} <= '0;
            {mem_branch, mem_byte_en, mem_halfword_en, mem_word_en} <= '0;
            {mem_r31_ctrl, mem_hlt} <= '0;
        end else if (flush) begin
            {mem_valid, mem_reg_write, mem_mem_to_reg, mem_mem_read, mem_mem_write} <= '0;
            {mem_branch, mem_byte_en, mem_halfword_en, mem_word_en} <= '0;
            {mem_r31_ctrl, mem_hlt} <= '0;
        end else begin
            mem_valid       <= ex_valid;
            mem_reg_write   <= ex_reg_write;
            mem_mem_to_reg  <= ex_mem_to_reg;
            mem_mem_read    <= ex_mem_read;
            mem_mem_write   <= ex_mem_write;
            mem_branch      <= ex_branch;
            mem_byte_en     <= ex_byte_en;
            mem_halfword_en <= ex_halfword_en;
            mem_word_en     <= ex_word_en;
            mem_r31_ctrl    <= ex_r31_ctrl;
            mem_hlt         <= ex_hlt;
        end
    end

    // Data fields follow the EX stage every cycle, flush or not
    always_ff @(posedge i_clock) begin
        mem_branch_addr  <= ex_branch_addr;
        mem_zero         <= ex_zero;
        mem_alu_result   <= ex_alu_result;
        mem_data_b       <= ex_data_b;
        mem_selected_reg <= ex_selected_reg;
        mem_pc           <= ex_pc;
    end

endmodule

// ==== source/data_memory.sv ====
`timescale 1ns/100ps

module data_memory #(
    parameter int mem_depth_words = 256
) (
    input  logic            i_clock,
    input  logic            write,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t store_data,
    input  logic            byte_en,
    input  logic            halfword_en,
    input  logic            word_en,
    output mips_pkg::word_t load_data
);

    import mips_pkg::*;

    localparam int addr_w = (mem_depth_words > 1) ? $clog2(mem_depth_words) : 1;

    word_t             mem [mem_depth_words];
    word_t             word_addr;
    logic [addr_w-1:0] word_idx;
    logic [3:0]        lane_we;
    word_t             wr_data;
    word_t             rd_word;

    assign word_addr = (addr >> 2) % mem_depth_words;   // Wraps around the depth
    assign word_idx  = word_addr[addr_w-1:0];

    initial begin
        for (int i = 0; i < mem_depth_words; i++) begin
            mem[i] = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Store lane selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        lane_we = 4'b0000;
        wr_data = store_data;
        if (byte_en) begin
            lane_we = 4'b0001 << addr[1:0];
            wr_data = {4{store_data[7:0]}};             // Same byte on every lane
        end else if (halfword_en) begin
            lane_we = addr[1] ? 4'b1100 : 4'b0011;
            wr_data = {2{store_data[15:0]}};
        end else if (word_en) begin
            lane_we = 4'b1111;
        end
    end

    always_ff @(posedge i_clock) begin
        if (write) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_we[i]) begin
                    mem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Load extraction, zero extended
    ////////////////////////////////////////////////////////////

    assign rd_word = mem[word_idx];

    always_comb begin
        if (byte_en) begin
            load_data = {24'd0, rd_word[8*addr[1:0] +: 8]};
        end else if (halfword_en) begin
            load_data = {16'd0, rd_word[16*addr[1] +: 16]};
        end else begin
            load_data = rd_word;
        end
    end

endmodule

// ==== source/mem_wb_reg.sv ====
`timescale 1ns/100ps

module mem_wb_reg (
    input  logic               i_clock,
    input  logic               rst_n,
    input  logic               mem_valid,
    input  logic               mem_reg_write,
    input  logic               mem_mem_to_reg,
    input  logic               mem_r31_ctrl,
    input  logic               mem_hlt,
    input  mips_pkg::reg_idx_t mem_selected_reg,
    input  mips_pkg::word_t    mem_alu_result,
    input  mips_pkg::word_t    load_data,
    input  mips_pkg::word_t    mem_pc,
    output logic               wb_write,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data,
    output logic               halted
);

    import mips_pkg::*;

    localparam reg_idx_t link_reg = reg_idx_t'(31);

    reg_idx_t next_reg;
    word_t    next_data;

    // Link instructions write the return address past the delay slot
    always_comb begin
        if (mem_r31_ctrl) begin
            next_reg  = link_reg;
            next_data = mem_pc + word_t'(8);
        end else begin
            next_reg  = mem_selected_reg;
            next_data = mem_mem_to_reg ? load_data : mem_alu_result;
        end
    end

    always_ff @(posedge i_clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_write <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_write <= mem_valid & mem_reg_write;      // One pulse per instruction
            halted   <= halted | (mem_valid & mem_hlt); // Sticky until reset
        end
    end

    always_ff @(posedge i_clock) begin
        wb_reg  <= next_reg;
        wb_data <= next_data;
    end

endmodule

// ==== source/ex_mem_pipeline.sv ====
`timescale 1ns/100ps

module ex_mem_pipeline #(
    parameter int mem_depth_words = 256
) (
    input  logic               i_clock,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               ex_valid,
    input  mips_pkg::alu_op_t  alu_op,
    input  mips_pkg::word_t    operand_a,
    input  mips_pkg::word_t    operand_b,
    input  mips_pkg::word_t    imm,
    input  mips_pkg::word_t    store_data,
    input  mips_pkg::word_t    pc,
    input  mips_pkg::reg_idx_t dest_reg,
    input  logic               reg_write,
    input  logic               mem_to_reg,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               branch,
    input  logic               byte_en,
    input  logic               halfword_en,
    input  logic               word_en,
    input  logic               r31_ctrl,
    input  logic               hlt,
    output logic               wb_write,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data,
    output logic               branch_taken,
    output mips_pkg::word_t    branch_target,
    output logic               halted
);

    import mips_pkg::*;

    word_t    ex_alu_result, ex_branch_addr;
    logic     ex_zero;
    logic     mem_valid, mem_reg_write, mem_mem_to_reg, mem_mem_read, mem_mem_write;
    logic     mem_branch, mem_byte_en, mem_halfword_en, mem_word_en, mem_r31_ctrl, mem_hlt;
    logic     mem_zero;
    word_t    mem_branch_addr, mem_alu_result, mem_data_b, mem_pc;
    reg_idx_t mem_selected_reg;
    word_t    load_data, mem_load_data;

    ////////////////////////////////////////////////////////////
    // EX stage
    ////////////////////////////////////////////////////////////

    execute_unit execute_unit_inst (
        .alu_op      (alu_op),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .imm         (imm),
        .pc          (pc),
        .alu_result  (ex_alu_result),
        .branch_addr (ex_branch_addr),
        .zero        (ex_zero)
    );

    ex_mem_reg ex_mem_reg_inst (
        .i_clock (i_clock), .rst_n (rst_n), .flush (flush), .ex_valid (ex_valid),
        .ex_reg_write (reg_write), .ex_mem_to_reg (mem_to_reg), .ex_mem_read (mem_read),
        .ex_mem_write (mem_write), .ex_branch (branch), .ex_byte_en (byte_en),
        .ex_halfword_en (halfword_en), .ex_word_en (word_en), .ex_r31_ctrl (r31_ctrl),
        .ex_hlt (hlt), .ex_branch_addr (ex_branch_addr), .ex_zero (ex_zero),
        .ex_alu_result (ex_alu_result), .ex_data_b (store_data),
        .ex_selected_reg (dest_reg), .ex_pc (pc),
        .mem_valid (mem_valid), .mem_reg_write (mem_reg_write),
        .mem_mem_to_reg (mem_mem_to_reg), .mem_mem_read (mem_mem_read),
        .mem_mem_write (mem_mem_write), .mem_branch (mem_branch),
        .mem_byte_en (mem_byte_en), .mem_halfword_en (mem_halfword_en),
        .mem_word_en (mem_word_en), .mem_r31_ctrl (mem_r31_ctrl), .mem_hlt (mem_hlt),
        .mem_branch_addr (mem_branch_addr), .mem_zero (mem_zero),
        .mem_alu_result (mem_alu_result), .mem_data_b (mem_data_b),
        .mem_selected_reg (mem_selected_reg), .mem_pc (mem_pc)
    );

    ////////////////////////////////////////////////////////////
    // MEM stage
    ////////////////////////////////////////////////////////////

    data_memory #(
        .mem_depth_words (mem_depth_words)
    ) data_memory_inst (
        .i_clock     (i_clock),
        .write       (mem_valid & mem_mem_write),
        .addr        (mem_alu_result),
        .store_data  (mem_data_b),
        .byte_en     (mem_byte_en),
        .halfword_en (mem_halfword_en),
        .word_en     (mem_word_en),
        .load_data   (load_data)
    );

    assign mem_load_data = mem_mem_read ? load_data : '0;  // Only loads pass memory data on
    assign branch_taken  = mem_valid & mem_branch & mem_zero;
    assign branch_target = mem_branch_addr;

    mem_wb_reg mem_wb_reg_inst (
        .i_clock          (i_clock),
        .rst_n            (rst_n),
        .mem_valid        (mem_valid),
        .mem_reg_write    (mem_reg_write),
        .mem_mem_to_reg   (mem_mem_to_reg),
        .mem_r31_ctrl     (mem_r31_ctrl),
        .mem_hlt          (mem_hlt),
        .mem_selected_reg (mem_selected_reg),
        .mem_alu_result   (mem_alu_result),
        .load_data        (mem_load_data),
        .mem_pc           (mem_pc),
        .wb_write         (wb_write),
        .wb_reg           (wb_reg),
        .wb_data          (wb_data),
        .halted           (halted)
    );

endmodule

// ==== tb/ex_mem_model.svh ====
// Shadow of the data memory, updated in program order when an instruction issues
word_t shadow_mem [mem_depth_words];

task automatic clear_shadow();
    for (int i = 0; i < mem_depth_words; i++) begin
        shadow_mem[i] = '0;
    end
endtask

function automatic int word_index(input word_t addr);
    return int'((addr >> 2) % mem_depth_words);           // Wraps around the depth
endfunction

function automatic word_t expected_alu(input alu_op_t op, input word_t a, input word_t b);
    word_t r;
    case (op)
        alu_add: r = a + b;
        alu_sub: r = a + ~b + 32'd1;
        alu_and: r = a & b;
        alu_or:  r = a | b;
        alu_xor: r = a ^ b;
        alu_nor: r = ~a & ~b;
        alu_slt: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};  // Sign first
        alu_sll: r = a << b[4:0];
        alu_srl: r = a >> b[4:0];
        default: r = '0;
    endcase
    return r;
endfunction

// Width is {byte, halfword, word}
function automatic word_t extract_load(input word_t addr, input logic [2:0] width);
    word_t w;
    w = shadow_mem[word_index(addr)];
    if (width[2]) begin
        return (w >> {addr[1:0], 3'b000}) & 32'h0000_00ff;
    end else if (width[1]) begin
        return (w >> {addr[1], 4'b0000}) & 32'h0000_ffff;
    end
    return w;
endfunction

task automatic apply_store(input word_t addr, input word_t data, input logic [2:0] width);
    word_t mask;
    word_t val;
    int    idx;
    idx  = word_index(addr);
    mask = '0;
    val  = data;
    if (width[2]) begin
        mask = 32'h0000_00ff << {addr[1:0], 3'b000};
        val  = {24'd0, data[7:0]} << {addr[1:0], 3'b000};
    end else if (width[1]) begin
        mask = 32'h0000_ffff << {addr[1], 4'b0000};
        val  = {16'd0, data[15:0]} << {addr[1], 4'b0000};
    end else if (width[0]) begin
        mask = 32'hffff_ffff;
    end
    shadow_mem[idx] = (shadow_mem[idx] & ~mask) | (val & mask);
endtask

// ==== tb/tb_ex_mem_pipeline.sv ====
`timescale 1ns/100ps

module tb_ex_mem_pipeline;

    import mips_pkg::*;

    localparam int mem_depth_words = 128;
    localparam int clk_period      = 4;
    localparam int n_reset         = 5;
    localparam int n_directed      = 80;                   // Upper bound on directed slots
    localparam int n_random        = 400;

    localparam logic [2:0] w_byte = 3'b100;
    localparam logic [2:0] w_half = 3'b010;
    localparam logic [2:0] w_word = 3'b001;

    // Control order {reg_write, mem_to_reg, mem_read, mem_write, branch, r31_ctrl, hlt}
    localparam logic [6:0] c_none   = 7'b0000000;
    localparam logic [6:0] c_alu    = 7'b1000000;
    localparam logic [6:0] c_load   = 7'b1110000;
    localparam logic [6:0] c_store  = 7'b0001000;
    localparam logic [6:0] c_branch = 7'b0000100;
    localparam logic [6:0] c_link   = 7'b1000010;
    localparam logic [6:0] c_halt   = 7'b0000001;

    logic     i_clock, rst_n, flush, ex_valid;
    alu_op_t  alu_op;
    word_t    operand_a, operand_b, imm, store_data, pc;
    reg_idx_t dest_reg;
    logic     reg_write, mem_to_reg, mem_read, mem_write, branch;
    logic     byte_en, halfword_en, word_en, r31_ctrl, hlt;
    logic     wb_write, branch_taken, halted;
    reg_idx_t wb_reg;
    word_t    wb_data, branch_target;

    int       cycle      = 0;
    int       n_errors   = 0;
    int       first_halt = 32'h3fff_ffff;
    word_t    next_pc    = 32'h0040_0000;

    // Four slots of expected outputs by issue cycle cover the two in flight
    logic     slot_wr [4];
    reg_idx_t slot_reg [4];
    word_t    slot_data [4];
    logic     slot_br [4];
    word_t    slot_target [4];
    logic [1:0] wb_slot, br_slot;
    logic     exp_wb_write, exp_branch, exp_halted;
    reg_idx_t exp_wb_reg;
    word_t    exp_wb_data, exp_target;

    `include "ex_mem_model.svh"

    ex_mem_pipeline #(
        .mem_depth_words (mem_depth_words)
    ) ex_mem_pipeline_inst (
        .i_clock (i_clock), .rst_n (rst_n), .flush (flush), .ex_valid (ex_valid),
        .alu_op (alu_op), .operand_a (operand_a), .operand_b (operand_b), .imm (imm),
        .store_data (store_data), .pc (pc), .dest_reg (dest_reg),
        .reg_write (reg_write), .mem_to_reg (mem_to_reg), .mem_read (mem_read),
        .mem_write (mem_write), .branch (branch), .byte_en (byte_en),
        .halfword_en (halfword_en), .word_en (word_en), .r31_ctrl (r31_ctrl), .hlt (hlt),
        .wb_write (wb_write), .wb_reg (wb_reg), .wb_data (wb_data),
        .branch_taken (branch_taken), .branch_target (branch_target), .halted (halted)
    );

    always #(clk_period / 2) i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle <= cycle + 1;
    end

    assign wb_slot      = 2'(cycle - 2);                  // Writeback lands two cycles on
    assign br_slot      = 2'(cycle - 1);
    assign exp_wb_write = slot_wr[wb_slot];
    assign exp_wb_reg   = slot_reg[wb_slot];
    assign exp_wb_data  = slot_data[wb_slot];
    assign exp_branch   = slot_br[br_slot];
    assign exp_target   = slot_target[br_slot];
    assign exp_halted   = (cycle >= first_halt + 2);

    ////////////////////////////////////////////////////////////
    // Checks sampled mid cycle where everything has settled
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input word_t exp_v, input word_t act_v);
        n_errors++;
        $display("FAILED %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
        $display("Checks failed");
        $fatal(1, "Mismatch on %s", name);
    endtask

    a_wb_write: assert property (@(negedge i_clock) disable iff (!rst_n)
        wb_write == exp_wb_write)
        else report_mismatch("wb_write", word_t'(exp_wb_write), word_t'(wb_write));
    a_wb_reg: assert property (@(negedge i_clock) disable iff (!rst_n)
        exp_wb_write |-> wb_reg == exp_wb_reg)
        else report_mismatch("wb_reg", word_t'(exp_wb_reg), word_t'(wb_reg));
    a_wb_data: assert property (@(negedge i_clock) disable iff (!rst_n)
        exp_wb_write |-> wb_data == exp_wb_data)
        else report_mismatch("wb_data", exp_wb_data, wb_data);
    a_branch: assert property (@(negedge i_clock) disable iff (!rst_n)
        branch_taken == exp_branch)
        else report_mismatch("branch_taken", word_t'(exp_branch), word_t'(branch_taken));
    a_target: assert property (@(negedge i_clock) disable iff (!rst_n)
        exp_branch |-> branch_target == exp_target)
        else report_mismatch("branch_target", exp_target, branch_target);
    a_halted: assert property (@(negedge i_clock) disable iff (!rst_n)
        halted == exp_halted)
        else report_mismatch("halted", word_t'(exp_halted), word_t'(halted));

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic issue(input logic v, input logic fl, input alu_op_t op, input word_t a,
                         input word_t b, input word_t imm_v, input word_t sd,
                         input reg_idx_t rd, input logic [6:0] ctl, input logic [2:0] width);
        word_t      res;
        logic [1:0] s;
        @(posedge i_clock);
        #1;
        ex_valid   = v;
        flush      = fl;
        alu_op     = op;
        operand_a  = a;
        operand_b  = b;
        imm        = imm_v;
        store_data = sd;
        pc         = next_pc;
        dest_reg   = rd;
        {reg_write, mem_to_reg, mem_read, mem_write, branch, r31_ctrl, hlt} = ctl;
        {byte_en, halfword_en, word_en} = width;
        res = expected_alu(op, a, b);
        s   = 2'(cycle);
        slot_wr[s] = 1'b0;
        slot_br[s] = 1'b0;
        if (v && !fl) begin
            slot_wr[s]     = ctl[6];
            slot_reg[s]    = ctl[1] ? 5'd31 : rd;
            slot_br[s]     = ctl[2] && (res == '0);
            slot_target[s] = next_pc + 32'd4 + imm_v * 32'd4;
            if (ctl[1]) begin
                slot_data[s] = next_pc + 32'd8;
            end else if (ctl[5]) begin
                slot_data[s] = extract_load(res, width);
            end else begin
                slot_data[s] = res;
            end
            if (ctl[3]) begin
                apply_store(res, sd, width);
            end
            if (ctl[0] && first_halt > cycle) begin
                first_halt = cycle;
            end
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) issue(1'b0, 1'b0, alu_add, '0, '0, '0, '0, '0, c_none, '0);
    endtask

    initial begin
        int       kind;
        logic     fl;
        logic [2:0] width;
        word_t    addr_a;
        word_t    addr_b;
        void'($urandom(32'h6f53));
        {i_clock, rst_n, flush, ex_valid} = 4'b0000;
        alu_op = alu_add;
        {operand_a, operand_b, imm, store_data, pc, dest_reg} = '0;
        {reg_write, mem_to_reg, mem_read, mem_write, branch} = '0;
        {byte_en, halfword_en, word_en, r31_ctrl, hlt} = '0;
        for (int i = 0; i < 4; i++) begin
            {slot_wr[i], slot_br[i], slot_reg[i], slot_data[i], slot_target[i]} = '0;
        end
        clear_shadow();
        repeat (n_reset) @(posedge i_clock);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 9; i++) begin
            issue(1'b1, 1'b0, alu_op_t'(4'(i)), 32'h8000_00f3, 32'h0000_0105, '0, '0,
                  5'(i + 1), c_alu, '0);
            issue(1'b1, 1'b0, alu_op_t'(4'(i)), 32'h1234_5678, 32'hffff_ff9c, '0, '0,
                  5'(i + 10), c_alu, '0);
        end

        // Stores of every width around 0x40, then loads of every lane
        issue(1'b1, 1'b0, alu_add, 32'h40, '0, '0, 32'h1122_3344, '0, c_store, w_word);
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, 1'b0, alu_add, 32'h44, 32'(i), '0, 32'ha0 + 32'(i), '0, c_store, w_byte);
        end
        for (int i = 0; i < 2; i++) begin
            issue(1'b1, 1'b0, alu_add, 32'h48, 32'(2 * i), '0, 32'h5a5a_bee0 + 32'(i), '0,
                  c_store, w_half);
        end
        issue(1'b1, 1'b0, alu_add, 32'h4c, '0, '0, 32'hcafe_f00d, '0, c_store, w_word);
        for (int i = 0; i < 16; i++) begin
            issue(1'b1, 1'b0, alu_add, 32'h40, 32'(i), '0, '0, 5'(i), c_load, w_byte);
        end
        for (int i = 0; i < 8; i++) begin
            issue(1'b1, 1'b0, alu_add, 32'h40, 32'(2 * i), '0, '0, 5'(i), c_load, w_half);
        end
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, 1'b0, alu_add, 32'h40, 32'(4 * i), '0, '0, 5'(i), c_load, w_word);
        end

        issue(1'b1, 1'b0, alu_sub, 32'h77, 32'h77, 32'h10, '0, '0, c_branch, '0);
        issue(1'b1, 1'b0, alu_sub, 32'h77, 32'h78, 32'h10, '0, '0, c_branch, '0);
        issue(1'b1, 1'b0, alu_xor, 32'h5, 32'h5, 32'hffff_fffd, '0, '0, c_branch, '0);

        // Flushed work must leave no trace
        issue(1'b1, 1'b1, alu_add, 32'h1, 32'h2, '0, '0, 5'd7, c_alu, '0);
        issue(1'b1, 1'b1, alu_sub, 32'h5, 32'h5, 32'h8, '0, '0, c_branch, '0);
        issue(1'b1, 1'b1, alu_add, 32'h40, '0, '0, 32'hdead_beef, '0, c_store, w_word);
        issue(1'b1, 1'b0, alu_add, 32'h40, '0, '0, '0, 5'd3, c_load, w_word);
        issue(1'b1, 1'b1, alu_add, '0, '0, '0, '0, '0, c_halt, '0);
        idle(1);

        issue(1'b1, 1'b0, alu_add, '0, '0, '0, '0, 5'd5, c_link, '0);
        issue(1'b1, 1'b0, alu_or, 32'h3, 32'h4, '0, '0, 5'd9, c_link, '0);
        issue(1'b1, 1'b0, alu_add, '0, '0, '0, '0, '0, c_halt, '0);
        for (int i = 0; i < 3; i++) begin
            issue(1'b1, 1'b0, alu_add, 32'(i), 32'h10, '0, '0, 5'd2, c_alu, '0);
        end

        for (int n = 0; n < n_random; n++) begin
            kind   = int'($urandom % 8);
            fl     = ($urandom % 16) == 0;
            width  = 3'b001 << ($urandom % 3);
            addr_a = $urandom & 32'hffff_fc00;                // Upper bits exercise the wrap
            addr_b = $urandom % 64;
            if (kind < 4) begin
                issue(1'b1, fl, alu_op_t'(4'($urandom % 9)), $urandom, $urandom, $urandom,
                      $urandom, 5'($urandom), c_alu, '0);
            end else if (kind < 6) begin
                issue(1'b1, fl, alu_add, addr_a, addr_b, '0, $urandom, '0, c_store, width);
            end else if (kind < 7) begin
                issue(1'b1, fl, alu_add, addr_a, addr_b, '0, '0, 5'($urandom), c_load, width);
            end else begin
                issue(1'b1, fl, alu_sub, $urandom % 4, $urandom % 4, $urandom, '0, '0,
                      c_branch, '0);
            end
        end
        idle(3);

        if (n_errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "Errors were found during the run");
        end
    end

    initial begin
        #((n_reset + n_directed + n_random + 50) * clk_period);
        $display("Checks failed");
        $fatal(1, "Watchdog timeout, the run did not finish in time");
    end

endmodule

// ==== src.f ====
+incdir+tb
source/mips_pkg.sv
source/execute_unit.sv
source/ex_mem_reg.sv
source/data_memory.sv
source/mem_wb_reg.sv
source/ex_mem_pipeline.sv
tb/tb_ex_mem_pipeline.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_ex_mem_pipeline -f src.f \
    && ./obj_dir/Vtb_ex_mem_pipeline | tee /dev/stderr | grep -F "All checks passed" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
